/* list.f */
cachePkg.sv
cacheFill.sv
cacheBank.sv
memArbiter.sv
mainMemory.sv
memSystem.sv
tbMemSystem.sv

/* Makefile */
TOP = tbMemSystem
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* tbMemSystem.sv */
`timescale 1ns/1ps

module tbMemSystem;

	localparam int numSets = 16;
	localparam int numRandom = 150;
	// directed requests plus the random ones on both ports
	localparam int totalReqs = 14 + 2 * numRandom;
	localparam int watchCycles = totalReqs * 40 + 200;
	// 1 + 8 + memory latency + 1 with no contention
	localparam int missCycles = 14;
	localparam logic [15:0] pattern = 16'hA5C3;

	typedef struct packed {
		logic [15:0] data;
		logic hit;
		logic [31:0] cyc;
	} expEntry_t;

	logic clk = 1'b0;
	logic rst;
	logic iReqValid;
	logic iReqReady;
	logic iRespValid;
	logic dReqValid;
	logic dReqReady;
	logic dRespValid;
	cachePkg::portReq_t iReq;
	cachePkg::portReq_t dReq;
	cachePkg::portResp_t iResp;
	cachePkg::portResp_t dResp;

	// port views indexed 0 for instruction, 1 for data
	logic [1:0] reqV;
	logic [1:0] reqR;
	logic [1:0] respV;
	logic [15:0] reqA [2];
	logic [15:0] respD [2];

	logic [31:0] cyc = '0;
	expEntry_t expQ [2][$];
	bit refValid [2][numSets];
	int refTag [2][numSets];
	int acceptCnt [2];
	int respCnt [2];
	int checks = 0;
	int errors = 0;
	int flowErrors = 0;

	memSystem #(.numSets(numSets)) uut (
		.clk(clk), .rst(rst),
		.iReqValid(iReqValid), .iReq(iReq), .iReqReady(iReqReady),
		.iRespValid(iRespValid), .iResp(iResp),
		.dReqValid(dReqValid), .dReq(dReq), .dReqReady(dReqReady),
		.dRespValid(dRespValid), .dResp(dResp)
	);

	assign reqV = {dReqValid, iReqValid};
	assign reqR = {dReqReady, iReqReady};
	assign respV = {dRespValid, iRespValid};
	assign reqA[0] = iReq.addr;
	assign reqA[1] = dReq.addr;
	assign respD[0] = iResp.data;
	assign respD[1] = dResp.data;

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 32'd1;
	end

	// start value of a memory word, byte address rotated left by 3
	function automatic logic [15:0] memWord(input logic [15:0] a);
		logic [15:0] w;
		w = {a[15:1], 1'b0};
		return ((w << 3) | (w >> 13)) ^ pattern;
	endfunction

	//////////////////////////////////////////////////
	// compare, sampled on the falling edge
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		expEntry_t e;
		logic [11:0] blk;
		int setIdx;
		int tagVal;
		if (rst) begin
			// reset empties the tag model as well
			for (int p = 0; p < 2; p++) begin
				for (int s = 0; s < numSets; s++) begin
					refValid[p][s] = 1'b0;
				end
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				// answer first, a new request may be taken in the same cycle
				if (respV[p]) begin
					// every answer counts, expected or not
					respCnt[p]++;
					assert (expQ[p].size() > 0) else begin
						errors++;
						$display("ERROR at %0t: port %0d answered with no request pending",
							$time, p);
					end
					assert (reqR[p]) else begin
						errors++;
						$display("ERROR at %0t: port %0d not ready while answering", $time, p);
					end
					if (expQ[p].size() > 0) begin
						e = expQ[p].pop_front();
						checks++;
						assert (respD[p] == e.data) else begin
							errors++;
							$display("ERROR at %0t: port %0d data %h, expected %h",
								$time, p, respD[p], e.data);
						end
						if (e.hit) begin
							assert (cyc - e.cyc == 32'd1) else begin
								errors++;
								$display("ERROR at %0t: port %0d hit took %0d cycles",
									$time, p, cyc - e.cyc);
							end
						end else begin
							assert (cyc - e.cyc >= 32'(missCycles)) else begin
								errors++;
								$display("ERROR at %0t: port %0d miss took only %0d cycles",
									$time, p, cyc - e.cyc);
							end
						end
					end
				end
				// accepted at the coming edge, predict hit from the tag model
				if (reqV[p] && reqR[p]) begin
					blk = reqA[p][15:4];
					setIdx = int'(blk) % numSets;
					tagVal = int'(blk) / numSets;
					e.hit = refValid[p][setIdx] && (refTag[p][setIdx] == tagVal);
					e.data = memWord(reqA[p]);
					e.cyc = cyc;
					refValid[p][setIdx] = 1'b1;
					refTag[p][setIdx] = tagVal;
					expQ[p].push_back(e);
					acceptCnt[p]++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus tasks, entered just after a rising edge
	//////////////////////////////////////////////////

	task automatic applyReset();
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (respV == 2'b00 && reqR == 2'b11) else begin
			flowErrors++;
			$display("ERROR at %0t: ports not idle after reset", $time);
		end
		@(posedge clk);
	endtask

	task automatic sendReq(input int p, input logic [15:0] a, input int gap);
		if (p == 0) begin
			iReqValid <= 1'b1;
			iReq.addr <= a;
		end else begin
			dReqValid <= 1'b1;
			dReq.addr <= a;
		end
		// ready only moves on the rising edge, so the falling edge sees the outcome
		do
			@(negedge clk);
		while (!reqR[p]);
		@(posedge clk);
		if (p == 0) begin
			iReqValid <= 1'b0;
		end else begin
			dReqValid <= 1'b0;
		end
		repeat (gap) @(posedge clk);
	endtask

	task automatic randomTraffic(input int p);
		logic [15:0] a;
		for (int n = 0; n < numRandom; n++) begin
			// small window keeps sets busy, now and then a far block
			a = 16'($urandom_range(0, 511)) << 1;
			if ($urandom_range(0, 7) == 0) begin
				a[15:10] = 6'($urandom);
			end
			sendReq(p, a, int'($urandom_range(0, 3)));
		end
	endtask

	task automatic waitIdle();
		do
			@(negedge clk);
		while (expQ[0].size() != 0 || expQ[1].size() != 0);
		@(posedge clk);
	endtask

	initial begin
		void'($urandom(32'hB174DA10));
		rst = 1'b1;
		iReqValid = 1'b0;
		dReqValid = 1'b0;
		iReq = '0;
		dReq = '0;
		applyReset();
		// cold miss, then the rest of the block hits
		sendReq(0, 16'h1234, 0);
		for (int w = 0; w < 8; w++) begin
			if (w != 2) begin
				sendReq(0, 16'h1230 + 16'(2 * w), 0);
			end
		end
		// same set, other tag, then back to the first block
		sendReq(0, 16'h1334, 0);
		sendReq(0, 16'h1234, 0);
		waitIdle();
		// both ports miss together
		fork
			sendReq(0, 16'h4A10, 0);
			sendReq(1, 16'h7B20, 0);
		join
		waitIdle();
		fork
			randomTraffic(0);
			randomTraffic(1);
		join
		waitIdle();
		// filled blocks are gone after reset
		applyReset();
		sendReq(1, 16'h7B22, 0);
		sendReq(0, 16'h1234, 1);
		waitIdle();
		for (int p = 0; p < 2; p++) begin
			assert (acceptCnt[p] == respCnt[p]) else begin
				flowErrors++;
				$display("ERROR at %0t: port %0d took %0d requests but gave %0d answers",
					$time, p, acceptCnt[p], respCnt[p]);
			end
		end
		$display("answers %0d/%0d, checks %0d, errors %0d", respCnt[0], respCnt[1],
			checks, errors + flowErrors);
		if (errors + flowErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// bound from the request count, each request well under 40 cycles
	initial begin
		repeat (watchCycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", watchCycles);
		$display("Errors found");
		$finish;
	end

endmodule

/* memSystem.sv */
`timescale 1ns/1ps

module memSystem #(
	parameter int numSets = 16
) (
	input logic clk,
	input logic rst,
	input logic iReqValid,
	input cachePkg::portReq_t iReq,
	output logic iReqReady,
	output logic iRespValid,
	output cachePkg::portResp_t iResp,
	input logic dReqValid,
	input cachePkg::portReq_t dReq,
	output logic dReqReady,
	output logic dRespValid,
	output cachePkg::portResp_t dResp
);

	//////////////////////////////////////////////////
	// bank to arbiter
	//////////////////////////////////////////////////

	logic iFillReqValid;
	logic iFillReqReady;
	logic iFillRespValid;
	cachePkg::memReq_t iFillReq;
	cachePkg::memResp_t iFillResp;
	logic dFillReqValid;
	logic dFillReqReady;
	logic dFillRespValid;
	cachePkg::memReq_t dFillReq;
	cachePkg::memResp_t dFillResp;

	// arbiter to memory
	logic memReqValid;
	logic memReqReady;
	logic memRespValid;
	cachePkg::memReq_t memReq;
	cachePkg::memResp_t memResp;

	// instruction side
	cacheBank #(.numSets(numSets)) instBank (
		.clk(clk), .rst(rst),
		.reqValid(iReqValid), .req(iReq), .reqReady(iReqReady),
		.respValid(iRespValid), .resp(iResp),
		.fillReqValid(iFillReqValid), .fillReq(iFillReq), .fillReqReady(iFillReqReady),
		.fillRespValid(iFillRespValid), .fillResp(iFillResp)
	);

	// data side
	cacheBank #(.numSets(numSets)) dataBank (
		.clk(clk), .rst(rst),
		.reqValid(dReqValid), .req(dReq), .reqReady(dReqReady),
		.respValid(dRespValid), .resp(dResp),
		.fillReqValid(dFillReqValid), .fillReq(dFillReq), .fillReqReady(dFillReqReady),
		.fillRespValid(dFillRespValid), .fillResp(dFillResp)
	);

	memArbiter arbiter (
		.clk(clk), .rst(rst),
		.iReqValid(iFillReqValid), .iReq(iFillReq), .iReqReady(iFillReqReady),
		.iRespValid(iFillRespValid), .iResp(iFillResp),
		.dReqValid(dFillReqValid), .dReq(dFillReq), .dReqReady(dFillReqReady),
		.dRespValid(dFillRespValid), .dResp(dFillResp),
		.memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
		.memRespValid(memRespValid), .memResp(memResp)
	);

	mainMemory memory (
		.clk(clk), .rst(rst),
		.memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
		.memRespValid(memRespValid), .memResp(memResp)
	);

endmodule

/* mainMemory.sv */
`timescale 1ns/1ps

module mainMemory (
	input logic clk,
	input logic rst,
	input logic memReqValid,
	input cachePkg::memReq_t memReq,
	output logic memReqReady,
	output logic memRespValid,
	output cachePkg::memResp_t memResp
);

	localparam int lat = cachePkg::memLatency;
	// 64 KiB of 16-bit words
	localparam int memWords = 32768;

	logic [cachePkg::wordWidth-1:0] mem [memWords];
	// read pipeline, one stage per cycle of latency
	logic [lat-1:0] vPipe;
	cachePkg::memResp_t dPipe [lat];

	// rotate byte address left by 3, then mix in the pattern
	function automatic logic [15:0] initWord(input logic [15:0] byteAddr);
		return {byteAddr[12:0], byteAddr[15:13]} ^ cachePkg::initPattern;
	endfunction

	initial begin
		for (int w = 0; w < memWords; w++) begin
			mem[w] = initWord(16'(w * 2));
		end
	end

	// model never stalls, one read per cycle
	assign memReqReady = 1'b1;
	assign memRespValid = vPipe[lat-1];
	assign memResp = dPipe[lat-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			vPipe <= '0;
		end else begin
			vPipe <= {vPipe[lat-2:0], memReqValid && memReqReady};
		end
	end

	// word address, top bit unused
	always_ff @(posedge clk) begin
		dPipe[0].data <= mem[memReq.addr[14:0]];
		for (int s = 1; s < lat; s++) begin
			dPipe[s] <= dPipe[s-1];
		end
	end

endmodule

/* memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
	input logic clk,
	input logic rst,
	input logic iReqValid,
	input cachePkg::memReq_t iReq,
	output logic iReqReady,
	output logic iRespValid,
	output cachePkg::memResp_t iResp,
	input logic dReqValid,
	input cachePkg::memReq_t dReq,
	output logic dReqReady,
	output logic dRespValid,
	output cachePkg::memResp_t dResp,
	output logic memReqValid,
	output cachePkg::memReq_t memReq,
	input logic memReqReady,
	input logic memRespValid,
	input cachePkg::memResp_t memResp
);

	localparam int lat = cachePkg::memLatency;

	// round-robin pointer, high when the data bank won last
	logic lastD;
	logic grantI;
	logic grantD;
	logic fire;
	// source id of each word in flight, 1 means data bank
	logic [lat-1:0] srcValid;
	logic [lat-1:0] srcId;

	//////////////////////////////////////////////////
	// grant
	//////////////////////////////////////////////////

	// on contention the bank that lost last time goes first
	assign grantI = iReqValid && (!dReqValid || lastD);
	assign grantD = dReqValid && !grantI;

	assign memReqValid = iReqValid || dReqValid;
	assign memReq = grantD ? dReq : iReq;
	// loser sees ready low and holds its request
	assign iReqReady = grantI && memReqReady;
	assign dReqReady = grantD && memReqReady;
	assign fire = memReqValid && memReqReady;

	//////////////////////////////////////////////////
	// return steering
	//////////////////////////////////////////////////

	// oldest entry lines up with the memory output
	assign iRespValid = memRespValid && srcValid[lat-1] && !srcId[lat-1];
	assign dRespValid = memRespValid && srcValid[lat-1] && srcId[lat-1];
	assign iResp = memResp;
	assign dResp = memResp;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastD <= 1'b0;
			srcValid <= '0;
		end else begin
			if (fire) begin
				lastD <= grantD;
			end
			srcValid <= {srcValid[lat-2:0], fire};
		end
	end

	always_ff @(posedge clk) begin
		srcId <= {srcId[lat-2:0], grantD};
	end

endmodule

/* cacheBank.sv */
`timescale 1ns/1ps

module cacheBank #(
	parameter int numSets = 16
) (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input cachePkg::portReq_t req,
	output logic reqReady,
	output logic respValid,
	output cachePkg::portResp_t resp,
	output logic fillReqValid,
	output cachePkg::memReq_t fillReq,
	input logic fillReqReady,
	input logic fillRespValid,
	input cachePkg::memResp_t fillResp
);

	// address split: tag | index | word offset | byte
	localparam int offBits = $clog2(cachePkg::wordsPerBlock);
	localparam int blockLsb = offBits + 1;
	localparam int idxBits = $clog2(numSets);
	localparam int tagBits = cachePkg::addrWidth - blockLsb - idxBits;

	//////////////////////////////////////////////////
	// arrays
	//////////////////////////////////////////////////

	logic [tagBits-1:0] tagArr [numSets];
	logic [numSets-1:0] validArr;
	// data indexed by {set, word offset}
	logic [cachePkg::wordWidth-1:0] dataArr [numSets*cachePkg::wordsPerBlock];

	// request currently being answered or filled
	cachePkg::portReq_t pendReq;
	logic [idxBits-1:0] reqIdx;
	logic [idxBits-1:0] pendIdx;
	logic [tagBits-1:0] reqTag;
	logic [tagBits-1:0] pendTag;
	logic [offBits-1:0] pendOff;
	logic accept;
	logic hit;

	// fill engine reports
	logic fillBusy;
	logic wordWrite;
	logic [offBits-1:0] wordOffset;
	logic [cachePkg::wordWidth-1:0] wordData;
	logic tagWrite;

	assign reqIdx = req.addr[blockLsb +: idxBits];
	assign reqTag = req.addr[cachePkg::addrWidth-1 -: tagBits];
	assign pendIdx = pendReq.addr[blockLsb +: idxBits];
	assign pendTag = pendReq.addr[cachePkg::addrWidth-1 -: tagBits];
	assign pendOff = pendReq.addr[1 +: offBits];

	//////////////////////////////////////////////////
	// handshake and hit detect
	//////////////////////////////////////////////////

	// port closes for the whole fill, from start to tag write
	assign reqReady = !fillBusy;
	assign accept = reqValid && reqReady;
	assign hit = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);

	// answer always comes from the array at the pending address
	assign resp.data = dataArr[{pendIdx, pendOff}];

	always_ff @(posedge clk) begin
		if (rst) begin
			respValid <= 1'b0;
			validArr <= '0;
		end else begin
			// hit answers next cycle, miss answers after the tag lands
			respValid <= (accept && hit) || tagWrite;
			if (tagWrite) begin
				validArr[pendIdx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pendReq <= req;
		end
		if (wordWrite) begin
			dataArr[{pendIdx, wordOffset}] <= wordData;
		end
		if (tagWrite) begin
			tagArr[pendIdx] <= pendTag;
		end
	end

	// miss starts the engine on the acceptance cycle
	cacheFill fill (
		.clk(clk),
		.rst(rst),
		.start(accept && !hit),
		.blockAddr(13'(req.addr[cachePkg::addrWidth-1:blockLsb])),
		.fillReqValid(fillReqValid),
		.fillReq(fillReq),
		.fillReqReady(fillReqReady),
		.fillRespValid(fillRespValid),
		.fillResp(fillResp),
		.busy(fillBusy),
		.wordWrite(wordWrite),
		.wordOffset(wordOffset),
		.wordData(wordData),
		.tagWrite(tagWrite)
	);

endmodule

/* cacheFill.sv */
`timescale 1ns/1ps

module cacheFill (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [12:0] blockAddr,
	output logic fillReqValid,
	output cachePkg::memReq_t fillReq,
	input logic fillReqReady,
	input logic fillRespValid,
	input cachePkg::memResp_t fillResp,
	output logic busy,
	output logic wordWrite,
	output logic [2:0] wordOffset,
	output logic [15:0] wordData,
	output logic tagWrite
);

	// block number of the miss being served
	logic [12:0] blockReg;
	// reads issued so far, 0..8
	logic [3:0] issueCnt;
	// words returned so far, wraps after the eighth
	logic [2:0] retCnt;
	// engine is between start and the last return
	logic active;
	logic lastRet;

	//////////////////////////////////////////////////
	// request side
	//////////////////////////////////////////////////

	// keep issuing until all eight reads are out, returns are counted apart
	assign fillReqValid = active && (issueCnt < 4'(cachePkg::wordsPerBlock));
	// word address is block number followed by the word offset
	assign fillReq.addr = {blockReg, issueCnt[2:0]};

	// eighth word coming back closes the fill
	assign lastRet = active && fillRespValid &&
		(retCnt == 3'(cachePkg::wordsPerBlock - 1));

	// tagWrite still counts as busy so the bank keeps the port closed
	assign busy = active || tagWrite;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			issueCnt <= '0;
			retCnt <= '0;
			wordWrite <= 1'b0;
			tagWrite <= 1'b0;
		end else begin
			// each return becomes one array write a cycle later
			wordWrite <= active && fillRespValid;
			tagWrite <= lastRet;
			if (start && !busy) begin
				active <= 1'b1;
				issueCnt <= '0;
				retCnt <= '0;
			end else if (active) begin
				if (fillReqValid && fillReqReady) begin
					issueCnt <= issueCnt + 4'd1;
				end
				if (fillRespValid) begin
					retCnt <= retCnt + 3'd1;
				end
				if (lastRet) begin
					active <= 1'b0;
				end
			end
		end
	end

	// payload registers, no reset needed
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			blockReg <= blockAddr;
		end
		// returns arrive in issue order, so the return count is the offset
		wordOffset <= retCnt;
		wordData <= fillResp.data;
	end

endmodule

/* cachePkg.sv */
package cachePkg;

	//////////////////////////////////////////////////
	// geometry
	//////////////////////////////////////////////////

	// byte address width, words are 2-byte aligned
	localparam int addrWidth = 16;
	// width of one data word
	localparam int wordWidth = 16;
	// 16-byte block holds eight words
	localparam int wordsPerBlock = 8;
	// cycles from accepted memory request to returned word
	localparam int memLatency = 4;

	// memory word at byte address a starts as rotl3(a) ^ initPattern
	localparam logic [wordWidth-1:0] initPattern = 16'hA5C3;

	//////////////////////////////////////////////////
	// payloads
	//////////////////////////////////////////////////

	// read request from a processor port, byte address
	typedef struct packed {
		logic [addrWidth-1:0] addr;
	} portReq_t;

	// word returned to a processor port
	typedef struct packed {
		logic [wordWidth-1:0] data;
	} portResp_t;

	// word address sent to main memory
	typedef struct packed {
		logic [addrWidth-1:0] addr;
	} memReq_t;

	// word returned by main memory
	typedef struct packed {
		logic [wordWidth-1:0] data;
	} memResp_t;

endpackage
